// ==== Makefile ====
# Verilator build and run for the execute-and-commit slice

VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(wildcard verilog/*.sv) $(wildcard sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR)

// ==== list.f ====
verilog/exec_pkg.sv
verilog/skid_buffer.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/commit_arbiter.sv
verilog/exec_top.sv
sim/exec_checker.sv
sim/exec_tb.sv

// ==== sim/exec_checker.sv ====
`default_nettype none

module exec_checker (
    input wire                     clk,
    input wire                     reset,
    input wire                     alu_req_valid,
    input wire                     alu_req_ready,
    input wire exec_pkg::alu_req_t alu_req,
    input wire                     mul_req_valid,
    input wire                     mul_req_ready,
    input wire exec_pkg::mul_req_t mul_req,
    input wire                     commit_valid,
    input wire                     commit_ready,
    input wire exec_pkg::commit_t  commit
);
    timeunit 1ns;
    timeprecision 1ps;

    // ############################################################
    // stalled transfers hold valid and payload
    // ############################################################

    assert property (@(posedge clk) disable iff (reset)
        alu_req_valid && !alu_req_ready |=> alu_req_valid && $stable(alu_req))
        else $error("ALU request dropped or changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        mul_req_valid && !mul_req_ready |=> mul_req_valid && $stable(mul_req))
        else $error("multiplier request dropped or changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else $error("commit dropped or changed while stalled");

    // one reset edge clears the output register
    assert property (@(posedge clk) $past(reset) |-> !commit_valid)
        else $error("commit_valid high during reset");

endmodule

bind exec_top exec_checker i_checker (
    .clk           (clk),
    .reset         (reset),
    .alu_req_valid (alu_req_valid),
    .alu_req_ready (alu_req_ready),
    .alu_req       (alu_req),
    .mul_req_valid (mul_req_valid),
    .mul_req_ready (mul_req_ready),
    .mul_req       (mul_req),
    .commit_valid  (commit_valid),
    .commit_ready  (commit_ready),
    .commit        (commit)
);

`default_nettype wire

// ==== sim/exec_tb.sv ====
`default_nettype none

module exec_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    logic     clk;
    logic     reset;
    logic     alu_req_valid;
    logic     alu_req_ready;
    alu_req_t alu_req;
    logic     mul_req_valid;
    logic     mul_req_ready;
    mul_req_t mul_req;
    logic     commit_valid;
    logic     commit_ready;
    commit_t  commit;

    // ############################################################
    // stimulus queues and scoreboard
    // ############################################################

    alu_req_t    alu_req_q[$];
    mul_req_t    mul_req_q[$];
    commit_t     alu_exp_q[$];
    commit_t     mul_exp_q[$];
    string       alu_name_q[$];
    string       mul_name_q[$];
    int          alu_acc_q[$];   // acceptance edge per outstanding request
    int          mul_acc_q[$];

    int          total       = 0;
    int          checked     = 0;
    int          passed      = 0;
    int          errors      = 0;
    int          cycle       = 0;
    int          alu_streak  = 0;   // alu commits while a mul result waits
    int          mul_streak  = 0;
    bit          run_started = 1'b0;
    logic [31:0] lfsr_state  = 32'hbb44_f12d;

    exec_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .alu_req_valid (alu_req_valid),
        .alu_req_ready (alu_req_ready),
        .alu_req       (alu_req),
        .mul_req_valid (mul_req_valid),
        .mul_req_ready (mul_req_ready),
        .mul_req       (mul_req),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // galois form with taps 32 22 2 1
    function automatic logic next_random_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic int random_value(input int nbits);
        int value;
        int i;
        value = 0;
        for (i = 0; i < nbits; i++) begin
            value = (value << 1) | int'(next_random_bit());
        end
        return value;
    endfunction

    task automatic load_tests();
        int          fd;
        int          n;
        int          op;
        int          tag;
        string       line;
        string       name;
        string       unit;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        alu_req_t    alu_item;
        mul_req_t    mul_item;
        commit_t     exp;
        fd = $fopen("sim/exec_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/exec_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 3 || line[0] == "#") begin
                    continue;   // comment or blank
                end
                n = $sscanf(line, "%s %s %d %h %h %d %h", name, unit, op, a, b, tag, expected);
                exp.tag  = tag[tag_bits-1:0];
                exp.data = expected;
                if (n != 7) begin
                    $display("malformed line in the test file: %0s", line);
                    errors++;
                end else if (unit == "alu") begin
                    alu_item = '{op: alu_op_e'(op[2:0]), a: a, b: b, tag: tag[tag_bits-1:0]};
                    exp.src  = unit_alu;
                    alu_req_q.push_back(alu_item);
                    alu_exp_q.push_back(exp);
                    alu_name_q.push_back(name);
                    total++;
                end else if (unit == "mul") begin
                    mul_item = '{op: mul_op_e'(op[0]), a: a, b: b, tag: tag[tag_bits-1:0]};
                    exp.src  = unit_mul;
                    mul_req_q.push_back(mul_item);
                    mul_exp_q.push_back(exp);
                    mul_name_q.push_back(name);
                    total++;
                end else begin
                    $display("test %0s names an unknown unit %0s", name, unit);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_result(input string name, input commit_t expected);
        checked++;
        if (commit !== expected) begin
            $display("[FAIL] %0s expected src %0d tag %0d data %h, actual src %0d tag %0d data %h",
                     name, expected.src, expected.tag, expected.data,
                     commit.src, commit.tag, commit.data);
            errors++;
        end else begin
            $display("[PASS] %0s tag %0d data %h", name, commit.tag, commit.data);
            passed++;
        end
    endtask

    task automatic check_commit(input int edge_no);
        commit_t exp;
        string   name;
        if (commit.src == unit_alu) begin
            mul_streak = 0;
            if (mul_acc_q.size() > 0 && edge_no - mul_acc_q[0] >= 3) begin
                alu_streak++;
            end
            if (alu_streak == 4) begin
                $display("ALU committed more than three results while a multiplier result waited");
                errors++;
            end
            if (alu_exp_q.size() == 0) begin
                $display("ALU result with tag %0d committed with no ALU request left", commit.tag);
                errors++;
            end else begin
                exp  = alu_exp_q.pop_front();
                name = alu_name_q.pop_front();
                if (alu_acc_q.size() > 0) begin
                    alu_acc_q.delete(0);
                end
                report_result(name, exp);
            end
        end else begin
            alu_streak = 0;
            if (alu_acc_q.size() > 0 && edge_no - alu_acc_q[0] >= 3) begin
                mul_streak++;
            end
            if (mul_streak == 4) begin
                $display("multiplier committed more than three results while an ALU result waited");
                errors++;
            end
            if (mul_exp_q.size() == 0) begin
                $display("multiplier result with tag %0d committed with no request left",
                         commit.tag);
                errors++;
            end else begin
                exp  = mul_exp_q.pop_front();
                name = mul_name_q.pop_front();
                if (mul_acc_q.size() > 0) begin
                    mul_acc_q.delete(0);
                end
                report_result(name, exp);
            end
        end
    endtask

    task automatic end_run();
        $display("tests %0d, checked %0d, passed %0d, errors %0d", total, checked, passed, errors);
        if (errors == 0 && total > 0 && checked == total) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // ############################################################
    // drivers
    // ############################################################

    initial begin : alu_driver
        alu_req_t item;
        int       gap;
        logic     taken;
        wait (run_started);
        @(posedge clk);
        while (alu_req_q.size() > 0) begin
            item = alu_req_q.pop_front();
            gap  = random_value(2);
            if (gap != 0) begin
                alu_req_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            alu_req_valid <= 1'b1;
            alu_req       <= item;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = alu_req_ready;   // registered, stable here
                @(posedge clk);
            end
        end
        alu_req_valid <= 1'b0;
    end

    initial begin : mul_driver
        mul_req_t item;
        int       gap;
        logic     taken;
        wait (run_started);
        @(posedge clk);
        while (mul_req_q.size() > 0) begin
            item = mul_req_q.pop_front();
            gap  = random_value(2);
            if (gap != 0) begin
                mul_req_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            mul_req_valid <= 1'b1;
            mul_req       <= item;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = mul_req_ready;
                @(posedge clk);
            end
        end
        mul_req_valid <= 1'b0;
    end

    initial begin : backpressure
        wait (run_started);
        forever begin
            @(posedge clk);
            commit_ready <= (random_value(2) != 0);   // ready about 3 of 4 cycles
        end
    end

    // transfers happen at the next rising edge
    always @(negedge clk) begin : monitor
        int edge_no;
        edge_no = cycle + 1;
        if (!reset) begin
            if (alu_req_valid && alu_req_ready) begin
                alu_acc_q.push_back(edge_no);
            end
            if (mul_req_valid && mul_req_ready) begin
                mul_acc_q.push_back(edge_no);
            end
            if (commit_valid && commit_ready) begin
                check_commit(edge_no);
            end
        end
    end

    initial begin : watchdog
        wait (run_started);
        while (cycle < 40 * total) begin
            @(posedge clk);
        end
        $display("run stopped after %0d cycles with %0d of %0d results committed",
                 cycle, checked, total);
        errors++;
        end_run();
    end

    initial begin : main
        reset         = 1'b1;
        alu_req_valid = 1'b0;
        alu_req       = '0;
        mul_req_valid = 1'b0;
        mul_req       = '0;
        commit_ready  = 1'b0;
        load_tests();
        if (total == 0 || errors != 0) begin
            $display("the test file gave no usable set of tests");
            end_run();
        end else begin
            repeat (8) @(posedge clk);
            reset       <= 1'b0;
            run_started = 1'b1;
            @(negedge clk);
            if (!alu_req_ready || !mul_req_ready) begin
                $display("request ready was low in the first cycle after reset");
                errors++;
            end
            while (checked < total) begin
                @(posedge clk);
            end
            repeat (20) @(posedge clk);   // room for stray commits
            end_run();
        end
    end

endmodule

`default_nettype wire

// ==== sim/exec_tests.txt ====
# columns: name unit op a b tag expected (a, b and expected in hex, tag in decimal)
# op codes: alu add=0 sub=1 and=2 or=3 xor=4 slt=5 sltu=6, mul mul=0 mulh=1
add_basic    alu 0 00000005 00000003  1 00000008
mul_small    mul 0 00000006 00000007 15 0000002a
add_wrap     alu 0 ffffffff 00000001  2 00000000
mulh_small   mul 1 00000006 00000007 16 00000000
sub_basic    alu 1 00000010 00000003  3 0000000d
mul_neg      mul 0 fffffffd 00000004 17 fffffff4
sub_neg      alu 1 00000003 00000005  4 fffffffe
mulh_neg     mul 1 fffffffd 00000004 18 ffffffff
and_mask     alu 2 f0f0f0f0 0ff00ff0  5 00f000f0
mul_negneg   mul 0 fffffffe fffffffd 19 00000006
or_mask      alu 3 f0f0f0f0 0ff00ff0  6 fff0fff0
mulh_negneg  mul 1 fffffffe fffffffd 20 00000000
xor_mask     alu 4 f0f0f0f0 0ff00ff0  7 ff00ff00
mulh_min_min mul 1 80000000 80000000 21 40000000
slt_neg      alu 5 ffffffff 00000001  8 00000001
mul_min_min  mul 0 80000000 80000000 22 00000000
sltu_neg     alu 6 ffffffff 00000001  9 00000000
mulh_max     mul 1 7fffffff 7fffffff 23 3fffffff
slt_pos      alu 5 00000007 00000003 10 00000000
mul_max      mul 0 7fffffff 7fffffff 24 00000001
sltu_small   alu 6 00000003 80000000 11 00000001
mulh_min_max mul 1 80000000 7fffffff 25 c0000000
slt_min      alu 5 80000000 7fffffff 12 00000001
mul_min_max  mul 0 80000000 7fffffff 26 80000000
add_big      alu 0 7fffffff 00000001 13 80000000
mulh_m1      mul 1 ffffffff ffffffff 27 00000000
xor_self     alu 4 12345678 12345678 14 00000000
mul_big      mul 0 00012345 00010000 28 23450000
mulh_big     mul 1 00012345 00010000 29 00000001

// ==== verilog/alu_unit.sv ====
`default_nettype none

module alu_unit #(
    parameter int xlen_p = exec_pkg::xlen,
    parameter int tag_p  = exec_pkg::tag_bits
) (
    input  wire               clk,
    input  wire               reset,

    input  wire               req_valid,
    output logic              req_ready,
    input  exec_pkg::alu_req_t req,

    output logic              rsp_valid,
    input  wire               rsp_ready,
    output exec_pkg::commit_t rsp
);
    import exec_pkg::*;

    logic [xlen_p-1:0] result;
    logic [xlen_p-1:0] data_q;
    logic [tag_p-1:0]  tag_q;
    logic              valid_q;
    logic              accept;

    always_comb begin
        case (req.op)
            alu_add:  result = req.a + req.b;
            alu_sub:  result = req.a - req.b;
            alu_and:  result = req.a & req.b;
            alu_or:   result = req.a | req.b;
            alu_xor:  result = req.a ^ req.b;
            alu_slt:  result = {{(xlen_p-1){1'b0}}, $signed(req.a) < $signed(req.b)};
            alu_sltu: result = {{(xlen_p-1){1'b0}}, req.a < req.b};
            default:  result = '0;
        endcase
    end

    assign req_ready = !valid_q || rsp_ready;   // empty or draining this cycle
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (req_ready) begin
            valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= result;
            tag_q  <= req.tag;
        end
    end

    assign rsp_valid = valid_q;
    assign rsp       = '{src: unit_alu, tag: tag_q, data: data_q};

endmodule

`default_nettype wire

// ==== verilog/commit_arbiter.sv ====
`default_nettype none

module commit_arbiter (
    input  wire               clk,
    input  wire               reset,

    input  wire               alu_valid,
    output logic              alu_ready,
    input  exec_pkg::commit_t alu_rsp,

    input  wire               mul_valid,
    output logic              mul_ready,
    input  exec_pkg::commit_t mul_rsp,

    output logic              out_valid,
    input  wire               out_ready,
    output exec_pkg::commit_t out
);

    logic prio_mul_q;   // 0 favours alu on a tie
    logic grant_alu;
    logic grant_mul;
    logic both_valid;
    logic fire;

    // ############################################################
    // grant
    // ############################################################

    assign both_valid = alu_valid && mul_valid;

    always_comb begin
        grant_alu = 1'b0;
        grant_mul = 1'b0;
        if (both_valid) begin
            grant_mul = prio_mul_q;
            grant_alu = !prio_mul_q;
        end else begin
            grant_alu = alu_valid;
            grant_mul = mul_valid;
        end
    end

    assign out_valid = alu_valid || mul_valid;
    assign out       = grant_mul ? mul_rsp : alu_rsp;
    assign alu_ready = grant_alu && out_ready;   // loser sees ready low
    assign mul_ready = grant_mul && out_ready;
    assign fire      = out_valid && out_ready;

    // ############################################################
    // round-robin priority
    // ############################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_mul_q <= 1'b0;
        end else if (fire && both_valid) begin
            prio_mul_q <= !prio_mul_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // ############################################################
    // widths
    // ############################################################

    parameter int xlen     = 32;
    parameter int tag_bits = 5;   // destination register index

    // ############################################################
    // opcodes
    // ############################################################

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_slt  = 3'd5,   // signed compare
        alu_sltu = 3'd6
    } alu_op_e;

    typedef enum logic {
        mul_mul  = 1'b0,   // low half of signed product
        mul_mulh = 1'b1    // high half of signed product
    } mul_op_e;

    typedef enum logic {
        unit_alu = 1'b0,
        unit_mul = 1'b1
    } unit_e;

    // ############################################################
    // stream payloads
    // ############################################################

    typedef struct packed {
        alu_op_e             op;
        logic [xlen-1:0]     a;
        logic [xlen-1:0]     b;
        logic [tag_bits-1:0] tag;
    } alu_req_t;   // 72 bits

    typedef struct packed {
        mul_op_e             op;
        logic [xlen-1:0]     a;
        logic [xlen-1:0]     b;
        logic [tag_bits-1:0] tag;
    } mul_req_t;   // 70 bits

    typedef struct packed {
        unit_e               src;
        logic [tag_bits-1:0] tag;
        logic [xlen-1:0]     data;
    } commit_t;    // 38 bits

endpackage

`default_nettype wire

// ==== verilog/exec_top.sv ====
`default_nettype none

module exec_top #(
    parameter int xlen_p = exec_pkg::xlen,
    parameter int tag_p  = exec_pkg::tag_bits
) (
    input  wire                clk,
    input  wire                reset,

    input  wire                alu_req_valid,
    output logic               alu_req_ready,
    input  exec_pkg::alu_req_t alu_req,

    input  wire                mul_req_valid,
    output logic               mul_req_ready,
    input  exec_pkg::mul_req_t mul_req,

    output logic               commit_valid,
    input  wire                commit_ready,
    output exec_pkg::commit_t  commit
);
    import exec_pkg::*;

    // buffered requests
    logic     alu_q_valid;
    logic     alu_q_ready;
    alu_req_t alu_q;
    logic     mul_q_valid;
    logic     mul_q_ready;
    mul_req_t mul_q;

    // unit results
    logic     alu_rsp_valid;
    logic     alu_rsp_ready;
    commit_t  alu_rsp;
    logic     mul_rsp_valid;
    logic     mul_rsp_ready;
    commit_t  mul_rsp;

    // arbiter output
    logic     arb_valid;
    logic     arb_ready;
    commit_t  arb_out;

    // ############################################################
    // input stages
    // ############################################################

    skid_buffer #(.payload_t(alu_req_t), .passthru(1'b0), .out_reg(1'b0)) alu_in_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (alu_req_valid),
        .ready_in  (alu_req_ready),
        .data_in   (alu_req),
        .valid_out (alu_q_valid),
        .ready_out (alu_q_ready),
        .data_out  (alu_q)
    );

    skid_buffer #(.payload_t(mul_req_t), .passthru(1'b0), .out_reg(1'b0)) mul_in_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mul_req_valid),
        .ready_in  (mul_req_ready),
        .data_in   (mul_req),
        .valid_out (mul_q_valid),
        .ready_out (mul_q_ready),
        .data_out  (mul_q)
    );

    // ############################################################
    // execution units
    // ############################################################

    alu_unit #(.xlen_p(xlen_p), .tag_p(tag_p)) i_alu (
        .clk       (clk),
        .reset     (reset),
        .req_valid (alu_q_valid),
        .req_ready (alu_q_ready),
        .req       (alu_q),
        .rsp_valid (alu_rsp_valid),
        .rsp_ready (alu_rsp_ready),
        .rsp       (alu_rsp)
    );

    mul_unit #(.xlen_p(xlen_p), .tag_p(tag_p)) i_mul (
        .clk       (clk),
        .reset     (reset),
        .req_valid (mul_q_valid),
        .req_ready (mul_q_ready),
        .req       (mul_q),
        .rsp_valid (mul_rsp_valid),
        .rsp_ready (mul_rsp_ready),
        .rsp       (mul_rsp)
    );

    // ############################################################
    // commit path
    // ############################################################

    commit_arbiter i_arb (
        .clk       (clk),
        .reset     (reset),
        .alu_valid (alu_rsp_valid),
        .alu_ready (alu_rsp_ready),
        .alu_rsp   (alu_rsp),
        .mul_valid (mul_rsp_valid),
        .mul_ready (mul_rsp_ready),
        .mul_rsp   (mul_rsp),
        .out_valid (arb_valid),
        .out_ready (arb_ready),
        .out       (arb_out)
    );

    skid_buffer #(.payload_t(commit_t), .passthru(1'b0), .out_reg(1'b1)) commit_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (arb_valid),
        .ready_in  (arb_ready),
        .data_in   (arb_out),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  (commit)
    );

endmodule

`default_nettype wire

// ==== verilog/mul_unit.sv ====
`default_nettype none

module mul_unit #(
    parameter int xlen_p = exec_pkg::xlen,
    parameter int tag_p  = exec_pkg::tag_bits
) (
    input  wire               clk,
    input  wire               reset,

    input  wire               req_valid,
    output logic              req_ready,
    input  exec_pkg::mul_req_t req,

    output logic              rsp_valid,
    input  wire               rsp_ready,
    output exec_pkg::commit_t rsp
);
    import exec_pkg::*;

    // stage 1 operands
    logic signed [2*xlen_p-1:0] a_s1;
    logic signed [2*xlen_p-1:0] b_s1;
    mul_op_e                    op_s1;
    logic [tag_p-1:0]           tag_s1;
    logic                       valid_s1;

    // stage 2 product
    logic signed [2*xlen_p-1:0] prod_s2;
    mul_op_e                    op_s2;
    logic [tag_p-1:0]           tag_s2;
    logic                       valid_s2;

    logic                       en;
    logic [xlen_p-1:0]          result;

    assign en        = !valid_s2 || rsp_ready;   // one enable for both stages
    assign req_ready = en;

    // ############################################################
    // valid bits
    // ############################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else if (en) begin
            valid_s1 <= req_valid;
            valid_s2 <= valid_s1;
        end
    end

    // ############################################################
    // datapath
    // ############################################################

    always_ff @(posedge clk) begin
        if (en && req_valid) begin
            a_s1   <= {{xlen_p{req.a[xlen_p-1]}}, req.a};   // sign extend
            b_s1   <= {{xlen_p{req.b[xlen_p-1]}}, req.b};
            op_s1  <= req.op;
            tag_s1 <= req.tag;
        end
        if (en && valid_s1) begin
            prod_s2 <= a_s1 * b_s1;
            op_s2   <= op_s1;
            tag_s2  <= tag_s1;
        end
    end

    assign result = (op_s2 == mul_mulh) ? prod_s2[2*xlen_p-1:xlen_p]
                                        : prod_s2[xlen_p-1:0];

    assign rsp_valid = valid_s2;
    assign rsp       = '{src: unit_mul, tag: tag_s2, data: result};

endmodule

`default_nettype wire

// ==== verilog/skid_buffer.sv ====
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic,
    parameter bit  passthru  = 1'b0,
    parameter bit  out_reg   = 1'b0
) (
    input  wire      clk,
    input  wire      reset,

    input  wire      valid_in,
    output logic     ready_in,
    input  payload_t data_in,

    output logic     valid_out,
    input  wire      ready_out,
    output payload_t data_out
);

    if (passthru) begin : g_passthru

        // ############################################################
        // wires only
        // ############################################################

        assign valid_out = valid_in;
        assign ready_in  = ready_out;
        assign data_out  = data_in;

    end else if (out_reg) begin : g_out_reg

        // ############################################################
        // output register plus one overflow entry
        // ############################################################

        payload_t out_q;
        payload_t spill_q;
        logic     valid_q;
        logic     spill_full_q;
        logic     take;
        logic     stall;

        assign take  = valid_in && ready_in;
        assign stall = valid_q && !ready_out;

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q      <= 1'b0;
                spill_full_q <= 1'b0;
            end else begin
                if (!stall) begin
                    valid_q <= valid_in || spill_full_q;
                end
                if (ready_out) begin
                    spill_full_q <= 1'b0;   // drained into out_q
                end else if (valid_in && valid_q) begin
                    spill_full_q <= 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (take) begin
                spill_q <= data_in;
            end
            if (!stall && !spill_full_q) begin
                out_q <= data_in;
            end else if (ready_out) begin
                out_q <= spill_q;
            end
        end

        assign ready_in  = !spill_full_q;   // registered, no path from ready_out
        assign valid_out = valid_q;
        assign data_out  = out_q;

    end else begin : g_two_entry

        // ############################################################
        // two word shift store with read pointer
        // ############################################################

        payload_t store_q [2];
        logic     rd_ptr_q;   // 1 when empty or holding two
        logic     valid_q;
        logic     ready_q;
        logic     push;
        logic     pop;

        assign push = valid_in && ready_q;
        assign pop  = valid_q && ready_out;

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q  <= 1'b0;
                ready_q  <= 1'b1;
                rd_ptr_q <= 1'b1;
            end else begin
                case ({push, pop})
                    2'b10: begin
                        valid_q <= 1'b1;
                        ready_q <= rd_ptr_q;   // full once the second word lands
                    end
                    2'b01: begin
                        ready_q <= 1'b1;
                        valid_q <= rd_ptr_q;
                    end
                    default: ;
                endcase
                if (push ^ pop) begin
                    rd_ptr_q <= !rd_ptr_q;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                store_q[1] <= store_q[0];
                store_q[0] <= data_in;
            end
        end

        assign ready_in  = ready_q;
        assign valid_out = valid_q;
        assign data_out  = store_q[rd_ptr_q];

    end

endmodule

`default_nettype wire
